// File: logic/slowVramPkg.sv
`default_nettype none

package slowVramPkg;

	// Widths on the slow VRAM side
	typedef logic [14:0] vramAddrT;
	typedef logic [15:0] vramDataT;

	// Fix layer map fields
	typedef logic [11:0] fixTileT;
	typedef logic [3:0] fixPalT;

	// Sprite map fields
	typedef logic [19:0] sprTileT;
	typedef logic [7:0] sprPalT;
	typedef logic [8:0] sprIndexT;
	typedef logic [4:0] tileRowT;

	// One value per cycle of the free-running slot counter
	typedef enum logic [2:0] {
		slotFixAddr,
		slotFixWait,
		slotSprEvenAddr,
		slotSprEvenWait,
		slotSprOddAddr,
		slotSprOddWait,
		slotCpuAddr,
		slotCpuWait
	} slotT;

	// Owner of a word coming out of the RAM
	typedef enum logic [1:0] {
		tagFix,
		tagSprEven,
		tagSprOdd,
		tagCpu
	} readTagT;

	// Fix map lives in the 0x7000 word block
	localparam logic [3:0] fixMapBase = 4'b1110;
	localparam int slotCount = 8;

endpackage

`default_nettype wire

// File: logic/cpuAccessIf.sv
`timescale 1ns/1ns
`default_nettype none

interface cpuAccessIf (
	input wire clk24M
);

	logic req;
	logic write;
	slowVramPkg::vramAddrT addr;
	slowVramPkg::vramDataT wdata;
	// High for one cycle during the CPU wait slot
	logic done;

	modport requester (
		input clk24M,
		input done,
		output req,
		output write,
		output addr,
		output wdata
	);

	modport server (
		input clk24M,
		input req,
		input write,
		input addr,
		input wdata,
		output done
	);

endinterface

`default_nettype wire

// File: logic/readStreamIf.sv
`timescale 1ns/1ns
`default_nettype none

interface readStreamIf;

	logic valid;
	slowVramPkg::readTagT tag;
	// Registered RAM output tied in at the top level
	slowVramPkg::vramDataT data;

	modport source (
		output valid,
		output tag
	);

	modport sink (
		input valid,
		input tag,
		input data
	);

endinterface

`default_nettype wire

// File: logic/cpuPortDecode.sv
`timescale 1ns/1ns
`default_nettype none

module cpuPortDecode (
	input wire clk24M,
	input wire rstN,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [15:0] paddr,
	input wire slowVramPkg::vramDataT pwdata,
	output logic pready,
	output logic pslverr,
	cpuAccessIf.requester cpu
);

	logic setupPhase;
	logic acceptSetup;
	logic errPending;

	// Setup phase lasts exactly one cycle
	assign setupPhase = psel && !penable;
	assign acceptSetup = setupPhase && !cpu.req && !errPending;

	always_ff @(posedge clk24M) begin
		if (!rstN) begin
			cpu.req <= 1'b0;
			errPending <= 1'b0;
			pready <= 1'b0;
			pslverr <= 1'b0;
		end else begin
			// Completion is one cycle behind done or the error flag
			pready <= cpu.done || errPending;
			pslverr <= errPending;
			errPending <= 1'b0;

			if (cpu.done) begin
				cpu.req <= 1'b0;
			end else if (acceptSetup) begin
				// Odd byte address never reaches the VRAM
				if (paddr[0]) begin
					errPending <= 1'b1;
				end else begin
					cpu.req <= 1'b1;
				end
			end
		end
	end

	// Request fields stay frozen while req is up
	always_ff @(posedge clk24M) begin
		if (acceptSetup) begin
			cpu.write <= pwrite;
			cpu.addr <= paddr[15:1];
			cpu.wdata <= pwdata;
		end
	end

endmodule

`default_nettype wire

// File: logic/slotSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module slotSequencer (
	input wire clk24M,
	input wire rstN,
	input wire [5:0] fixColumn,
	input wire [4:0] fixRow,
	input wire slowVramPkg::sprIndexT sprIndex,
	input wire slowVramPkg::tileRowT tileRow,
	cpuAccessIf.server cpu,
	output slowVramPkg::vramAddrT ramAddr,
	output logic ramWrite,
	output slowVramPkg::vramDataT ramWdata,
	readStreamIf.source rd
);

	slowVramPkg::slotT slot;
	slowVramPkg::vramAddrT fixAddr;
	slowVramPkg::vramAddrT sprEvenAddr;
	slowVramPkg::vramAddrT sprOddAddr;
	logic cpuServe;

	// Free-running slot counter
	always_ff @(posedge clk24M) begin
		if (!rstN) begin
			slot <= slowVramPkg::slotFixAddr;
		end else if (slot == slowVramPkg::slotT'(slowVramPkg::slotCount - 1)) begin
			slot <= slowVramPkg::slotFixAddr;
		end else begin
			slot <= slowVramPkg::slotT'(slot + 3'd1);
		end
	end

	assign fixAddr = {slowVramPkg::fixMapBase, fixColumn, fixRow};
	// Word bit picks the even or odd half of a sprite map entry
	assign sprEvenAddr = {sprIndex, tileRow, 1'b0};
	assign sprOddAddr = {sprIndex, tileRow, 1'b1};

	assign cpuServe = (slot == slowVramPkg::slotCpuAddr) && cpu.req;

	// Address mux holds through each wait slot
	always_comb begin
		unique case (slot)
			slowVramPkg::slotFixAddr,
			slowVramPkg::slotFixWait: ramAddr = fixAddr;
			slowVramPkg::slotSprEvenAddr,
			slowVramPkg::slotSprEvenWait: ramAddr = sprEvenAddr;
			slowVramPkg::slotSprOddAddr,
			slowVramPkg::slotSprOddWait: ramAddr = sprOddAddr;
			default: ramAddr = cpu.addr;
		endcase
	end

	assign ramWrite = cpuServe && cpu.write;
	assign ramWdata = cpu.wdata;

	always_ff @(posedge clk24M) begin
		if (!rstN) begin
			cpu.done <= 1'b0;
			rd.valid <= 1'b0;
			rd.tag <= slowVramPkg::tagFix;
		end else begin
			cpu.done <= cpuServe;
			rd.valid <= 1'b0;
			// Tag lines up with the registered RAM word
			unique case (slot)
				slowVramPkg::slotFixAddr: begin
					rd.valid <= 1'b1;
					rd.tag <= slowVramPkg::tagFix;
				end
				slowVramPkg::slotSprEvenAddr: begin
					rd.valid <= 1'b1;
					rd.tag <= slowVramPkg::tagSprEven;
				end
				slowVramPkg::slotSprOddAddr: begin
					rd.valid <= 1'b1;
					rd.tag <= slowVramPkg::tagSprOdd;
				end
				slowVramPkg::slotCpuAddr: begin
					// Idle CPU slot issues nothing
					rd.valid <= cpu.req;
					rd.tag <= slowVramPkg::tagCpu;
				end
				default: begin
					rd.valid <= 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/slowVramArray.sv
`timescale 1ns/1ns
`default_nettype none

module slowVramArray (
	input wire clk24M,
	input wire slowVramPkg::vramAddrT ramAddr,
	input wire ramWrite,
	input wire slowVramPkg::vramDataT ramWdata,
	output slowVramPkg::vramDataT ramRdata
);

	// One word per address value
	slowVramPkg::vramDataT mem [0:(1 << $bits(slowVramPkg::vramAddrT)) - 1];

	always_ff @(posedge clk24M) begin
		if (ramWrite) begin
			mem[ramAddr] <= ramWdata;
		end
	end

	// Old word comes out on a write cycle
	always_ff @(posedge clk24M) begin
		ramRdata <= mem[ramAddr];
	end

endmodule

`default_nettype wire

// File: logic/mapLatch.sv
`timescale 1ns/1ns
`default_nettype none

module mapLatch (
	input wire clk24M,
	input wire rstN,
	readStreamIf.sink rd,
	output slowVramPkg::fixTileT fixTile,
	output slowVramPkg::fixPalT fixPal,
	output slowVramPkg::sprTileT sprTile,
	output slowVramPkg::sprPalT sprPal,
	output logic sprVflip,
	output logic sprHflip,
	output logic [1:0] sprAutoAnim,
	output slowVramPkg::vramDataT cpuReadData
);

	// Low 16 tile bits wait here for the odd word
	slowVramPkg::vramDataT sprEvenHold;

	always_ff @(posedge clk24M) begin
		if (rd.valid && rd.tag == slowVramPkg::tagSprEven) begin
			sprEvenHold <= rd.data;
		end
	end

	always_ff @(posedge clk24M) begin
		if (!rstN) begin
			fixTile <= '0;
			fixPal <= '0;
			sprTile <= '0;
			sprPal <= '0;
			sprVflip <= 1'b0;
			sprHflip <= 1'b0;
			sprAutoAnim <= 2'b00;
			cpuReadData <= '0;
		end else if (rd.valid) begin
			unique case (rd.tag)
				slowVramPkg::tagFix: begin
					fixTile <= rd.data[11:0];
					fixPal <= rd.data[15:12];
				end
				slowVramPkg::tagSprOdd: begin
					// All sprite fields switch on the same edge
					sprTile <= {rd.data[7:4], sprEvenHold};
					sprPal <= rd.data[15:8];
					sprAutoAnim <= rd.data[3:2];
					sprVflip <= rd.data[1];
					sprHflip <= rd.data[0];
				end
				slowVramPkg::tagCpu: begin
					cpuReadData <= rd.data;
				end
				default: begin
					// Even word only goes to the hold register
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/slowVramTop.sv
`timescale 1ns/1ns
`default_nettype none

module slowVramTop (
	input wire clk24M,
	input wire rstN,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [15:0] paddr,
	input wire slowVramPkg::vramDataT pwdata,
	output slowVramPkg::vramDataT prdata,
	output logic pready,
	output logic pslverr,
	input wire [5:0] fixColumn,
	input wire [4:0] fixRow,
	input wire slowVramPkg::sprIndexT sprIndex,
	input wire slowVramPkg::tileRowT tileRow,
	output slowVramPkg::fixTileT fixTile,
	output slowVramPkg::fixPalT fixPal,
	output slowVramPkg::sprTileT sprTile,
	output slowVramPkg::sprPalT sprPal,
	output logic sprVflip,
	output logic sprHflip,
	output logic [1:0] sprAutoAnim
);

	slowVramPkg::vramAddrT ramAddr;
	slowVramPkg::vramDataT ramWdata;
	slowVramPkg::vramDataT ramRdata;
	slowVramPkg::vramDataT cpuReadData;
	logic ramWrite;

	cpuAccessIf cpuBus (.clk24M(clk24M));
	readStreamIf rdBus ();

	// RAM output feeds the read stream directly
	assign rdBus.data = ramRdata;
	assign prdata = cpuReadData;

	cpuPortDecode decode0 (
		.clk24M(clk24M),
		.rstN(rstN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pready(pready),
		.pslverr(pslverr),
		.cpu(cpuBus.requester)
	);

	slotSequencer seq0 (
		.clk24M(clk24M),
		.rstN(rstN),
		.fixColumn(fixColumn),
		.fixRow(fixRow),
		.sprIndex(sprIndex),
		.tileRow(tileRow),
		.cpu(cpuBus.server),
		.ramAddr(ramAddr),
		.ramWrite(ramWrite),
		.ramWdata(ramWdata),
		.rd(rdBus.source)
	);

	slowVramArray ram0 (
		.clk24M(clk24M),
		.ramAddr(ramAddr),
		.ramWrite(ramWrite),
		.ramWdata(ramWdata),
		.ramRdata(ramRdata)
	);

	mapLatch latch0 (
		.clk24M(clk24M),
		.rstN(rstN),
		.rd(rdBus.sink),
		.fixTile(fixTile),
		.fixPal(fixPal),
		.sprTile(sprTile),
		.sprPal(sprPal),
		.sprVflip(sprVflip),
		.sprHflip(sprHflip),
		.sprAutoAnim(sprAutoAnim),
		.cpuReadData(cpuReadData)
	);

endmodule

`default_nettype wire

// File: verif/slowVramModel.svh
`ifndef SLOW_VRAM_MODEL_SVH
`define SLOW_VRAM_MODEL_SVH

// Every word the CPU side has written so far
slowVramPkg::vramDataT shadowMem [0:(1 << $bits(slowVramPkg::vramAddrT)) - 1];

// Fix map entry of one screen cell
function automatic slowVramPkg::vramAddrT fixWordAddr(logic [5:0] column, logic [4:0] cellRow);
	return {slowVramPkg::fixMapBase, column, cellRow};
endfunction

// Sprite map entry where odd selects the second word
function automatic slowVramPkg::vramAddrT sprWordAddr(slowVramPkg::sprIndexT index,
		slowVramPkg::tileRowT rowInColumn, logic odd);
	return {index, rowInColumn, odd};
endfunction

function automatic slowVramPkg::fixTileT fixTileOf(slowVramPkg::vramDataT word);
	return word[11:0];
endfunction

function automatic slowVramPkg::fixPalT fixPalOf(slowVramPkg::vramDataT word);
	return word[15:12];
endfunction

// Even word gives the low 16 tile bits
function automatic slowVramPkg::sprTileT sprTileOf(slowVramPkg::vramDataT evenWord,
		slowVramPkg::vramDataT oddWord);
	return {oddWord[7:4], evenWord};
endfunction

function automatic slowVramPkg::sprPalT sprPalOf(slowVramPkg::vramDataT oddWord);
	return oddWord[15:8];
endfunction

function automatic logic [1:0] autoAnimOf(slowVramPkg::vramDataT oddWord);
	return oddWord[3:2];
endfunction

`endif

// File: verif/slowVramTb.sv
`timescale 1ns/1ns
`default_nettype none

module slowVramTb;

	logic clk24M;
	logic rstN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [15:0] paddr;
	slowVramPkg::vramDataT pwdata;
	slowVramPkg::vramDataT prdata;
	logic pready;
	logic pslverr;
	logic [5:0] fixColumn;
	logic [4:0] fixRow;
	slowVramPkg::sprIndexT sprIndex;
	slowVramPkg::tileRowT tileRow;
	slowVramPkg::fixTileT fixTile;
	slowVramPkg::fixPalT fixPal;
	slowVramPkg::sprTileT sprTile;
	slowVramPkg::sprPalT sprPal;
	logic sprVflip;
	logic sprHflip;
	logic [1:0] sprAutoAnim;

	logic [31:0] lfsrState;
	int errorCount;
	int checkCount;
	int testCount;
	int failedTests;
	// Map coordinates currently driven into the DUT
	logic [5:0] heldColumn;
	logic [4:0] heldRow;
	slowVramPkg::sprIndexT heldIndex;
	slowVramPkg::tileRowT heldTileRow;

	`include "slowVramModel.svh"

	slowVramTop dut0 (.*);

	always #20 clk24M = ~clk24M;

	function automatic logic [31:0] lfsrNext(logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] randBits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			r = {r[30:0], lfsrState[0]};
		end
		return r;
	endfunction

	task automatic compareValue(string name, logic [31:0] actual, logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic finishTest(string name, int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore) begin
			$display("test %s: ok", name);
		end else begin
			failedTests++;
			$display("test %s: failed with %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	// Setup phase and then access phase until pready or 12 cycles
	task automatic apbTransfer(input logic write, input logic [15:0] addr,
			input slowVramPkg::vramDataT wdata, output slowVramPkg::vramDataT rdata,
			output logic err, output int cycles);
		logic seen;
		seen = 1'b0;
		rdata = '0;
		err = 1'b0;
		cycles = 0;
		@(posedge clk24M);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk24M);
		penable <= 1'b1;
		while (!seen && cycles < 12) begin
			@(negedge clk24M);
			cycles++;
			if (pready) begin
				seen = 1'b1;
				rdata = prdata;
				err = pslverr;
			end
		end
		if (!seen) begin
			errorCount++;
			$display("ERROR at %0t ns: transfer to %h got no pready within 12 cycles", $time, addr);
		end
		@(posedge clk24M);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic writeWord(slowVramPkg::vramAddrT wordAddr, slowVramPkg::vramDataT data);
		slowVramPkg::vramDataT rdata;
		logic err;
		int cycles;
		apbTransfer(1'b1, {wordAddr, 1'b0}, data, rdata, err, cycles);
		compareValue("pslverr", 32'(err), 32'd0);
		shadowMem[wordAddr] = data;
	endtask

	task automatic readWord(slowVramPkg::vramAddrT wordAddr);
		slowVramPkg::vramDataT rdata;
		logic err;
		int cycles;
		apbTransfer(1'b0, {wordAddr, 1'b0}, '0, rdata, err, cycles);
		compareValue("pslverr", 32'(err), 32'd0);
		compareValue("prdata", 32'(rdata), 32'(shadowMem[wordAddr]));
	endtask

	task automatic pickCoords();
		heldColumn = 6'(randBits(6));
		heldRow = 5'(randBits(5));
		heldIndex = 9'(randBits(9));
		heldTileRow = 5'(randBits(5));
		@(posedge clk24M);
		fixColumn <= heldColumn;
		fixRow <= heldRow;
		sprIndex <= heldIndex;
		tileRow <= heldTileRow;
	endtask

	task automatic checkFix();
		slowVramPkg::vramDataT word;
		word = shadowMem[fixWordAddr(heldColumn, heldRow)];
		compareValue("fixTile", 32'(fixTile), 32'(fixTileOf(word)));
		compareValue("fixPal", 32'(fixPal), 32'(fixPalOf(word)));
	endtask

	task automatic checkSprite();
		slowVramPkg::vramDataT evenWord;
		slowVramPkg::vramDataT oddWord;
		evenWord = shadowMem[sprWordAddr(heldIndex, heldTileRow, 1'b0)];
		oddWord = shadowMem[sprWordAddr(heldIndex, heldTileRow, 1'b1)];
		compareValue("sprTile", 32'(sprTile), 32'(sprTileOf(evenWord, oddWord)));
		compareValue("sprPal", 32'(sprPal), 32'(sprPalOf(oddWord)));
		compareValue("sprAutoAnim", 32'(sprAutoAnim), 32'(autoAnimOf(oddWord)));
		compareValue("sprVflip", 32'(sprVflip), 32'(oddWord[1]));
		compareValue("sprHflip", 32'(sprHflip), 32'(oddWord[0]));
	endtask

	function automatic logic mapMatches();
		slowVramPkg::vramDataT fixWord;
		slowVramPkg::vramDataT evenWord;
		slowVramPkg::vramDataT oddWord;
		fixWord = shadowMem[fixWordAddr(heldColumn, heldRow)];
		evenWord = shadowMem[sprWordAddr(heldIndex, heldTileRow, 1'b0)];
		oddWord = shadowMem[sprWordAddr(heldIndex, heldTileRow, 1'b1)];
		return fixTile === fixTileOf(fixWord) && fixPal === fixPalOf(fixWord)
			&& sprTile === sprTileOf(evenWord, oddWord) && sprPal === sprPalOf(oddWord)
			&& sprAutoAnim === autoAnimOf(oddWord) && sprVflip === oddWord[1]
			&& sprHflip === oddWord[0];
	endfunction

	initial begin
		int errorsBefore;
		int waited;
		int cycles;
		slowVramPkg::vramAddrT addrList [$];
		slowVramPkg::vramAddrT wordAddr;
		slowVramPkg::vramDataT rdata;
		logic err;
		clk24M = 1'b0;
		rstN = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		fixColumn = '0;
		fixRow = '0;
		sprIndex = '0;
		tileRow = '0;
		lfsrState = 32'hfb0356d0;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		failedTests = 0;
		repeat (16) @(posedge clk24M);
		rstN <= 1'b1;

		// Outputs before the first fetch lands
		errorsBefore = errorCount;
		@(negedge clk24M);
		compareValue("pready", 32'(pready), 32'd0);
		compareValue("pslverr", 32'(pslverr), 32'd0);
		compareValue("prdata", 32'(prdata), 32'd0);
		compareValue("fixTile", 32'(fixTile), 32'd0);
		compareValue("fixPal", 32'(fixPal), 32'd0);
		compareValue("sprTile", 32'(sprTile), 32'd0);
		compareValue("sprPal", 32'(sprPal), 32'd0);
		compareValue("sprVflip", 32'(sprVflip), 32'd0);
		compareValue("sprHflip", 32'(sprHflip), 32'd0);
		compareValue("sprAutoAnim", 32'(sprAutoAnim), 32'd0);
		finishTest("reset values", errorsBefore);

		errorsBefore = errorCount;
		for (int i = 0; i < 64; i++) begin
			wordAddr = 15'(randBits(15));
			addrList.push_back(wordAddr);
			writeWord(wordAddr, 16'(randBits(16)));
		end
		foreach (addrList[i]) begin
			readWord(addrList[i]);
		end
		finishTest("APB round trip", errorsBefore);

		// Odd byte address must leave the even word alone
		errorsBefore = errorCount;
		for (int i = 0; i < 8; i++) begin
			wordAddr = 15'(randBits(15));
			writeWord(wordAddr, 16'(randBits(16)));
			apbTransfer(1'b1, {wordAddr, 1'b1}, 16'(randBits(16)), rdata, err, cycles);
			compareValue("pslverr", 32'(err), 32'd1);
			compareValue("error cycles", 32'(cycles), 32'd2);
			readWord(wordAddr);
		end
		finishTest("odd address", errorsBefore);

		errorsBefore = errorCount;
		for (int i = 0; i < 16; i++) begin
			pickCoords();
			writeWord(fixWordAddr(heldColumn, heldRow), 16'(randBits(16)));
			repeat (16) @(posedge clk24M);
			@(negedge clk24M);
			checkFix();
		end
		finishTest("fix fetch", errorsBefore);

		errorsBefore = errorCount;
		for (int i = 0; i < 16; i++) begin
			pickCoords();
			writeWord(sprWordAddr(heldIndex, heldTileRow, 1'b0), 16'(randBits(16)));
			writeWord(sprWordAddr(heldIndex, heldTileRow, 1'b1), 16'(randBits(16)));
			repeat (16) @(posedge clk24M);
			@(negedge clk24M);
			checkSprite();
		end
		finishTest("sprite fetch", errorsBefore);

		// Rewrite the words being fetched and wait up to 16 cycles for the outputs
		errorsBefore = errorCount;
		for (int i = 0; i < 16; i++) begin
			pickCoords();
			writeWord(sprWordAddr(heldIndex, heldTileRow, 1'b0), 16'(randBits(16)));
			writeWord(sprWordAddr(heldIndex, heldTileRow, 1'b1), 16'(randBits(16)));
			writeWord(fixWordAddr(heldColumn, heldRow), 16'(randBits(16)));
			waited = 0;
			@(negedge clk24M);
			while (!mapMatches() && waited < 16) begin
				@(negedge clk24M);
				waited++;
			end
			checkFix();
			checkSprite();
		end
		finishTest("mixed traffic", errorsBefore);

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testCount, failedTests, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+verif
logic/slowVramPkg.sv
logic/cpuAccessIf.sv
logic/readStreamIf.sv
logic/cpuPortDecode.sv
logic/slotSequencer.sv
logic/slowVramArray.sv
logic/mapLatch.sv
logic/slowVramTop.sv
verif/slowVramTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= slowVramTb
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qxF "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
